// File: verilog.f
hw/fetch_pkg.sv
hw/imem_port_if.sv
hw/fetch_issue.sv
hw/imem_bank.sv
hw/fetch_collect.sv
hw/fetch_top.sv
tests/fetch_sva.sv
tests/fetch_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_tb -f verilog.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/fetch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// File: tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int NUM_BANKS  = 4;
    localparam int BANK_DEPTH = 16;
    localparam int MEM_WORDS  = NUM_BANKS * BANK_DEPTH;
    localparam int IDX_W      = $clog2(MEM_WORDS);
    localparam int WAIT_LIMIT = 20; // cycles before a missing inst_valid counts as a hang

    logic             clk;
    logic             rst;
    logic             jump_en;
    word_t            jump_pc;
    logic             imem_we;
    logic [IDX_W-1:0] imem_waddr;
    word_t            imem_wdata;
    logic             inst_ready;
    logic             inst_valid;
    word_t            inst_pc;
    word_t            inst;

    word_t prog [MEM_WORDS]; // model copy of the loaded program
    word_t last_pc;          // pc of the last word taken
    int    n_tests;
    int    n_failed;
    int    n_errors;
    int    test_errors;

    fetch_top #(
        .NUM_BANKS (NUM_BANKS),
        .BANK_DEPTH(BANK_DEPTH)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .jump_en   (jump_en),
        .jump_pc   (jump_pc),
        .imem_we   (imem_we),
        .imem_waddr(imem_waddr),
        .imem_wdata(imem_wdata),
        .inst_ready(inst_ready),
        .inst_valid(inst_valid),
        .inst_pc   (inst_pc),
        .inst      (inst)
    );

    always #20 clk = ~clk; // 40 ns period

    // word at a pc, index wraps with the total memory size
    function automatic word_t model_word(word_t pc);
        logic [IDX_W-1:0] idx;
        idx = IDX_W'((pc - RESET_PC) >> 2);
        return prog[idx];
    endfunction

    task automatic error_word(string name, word_t got, word_t exp);
        $display("FAILED %s: got %h expected %h", name, got, exp);
        n_errors++;
        test_errors++;
    endtask

    task automatic flag_problem(string msg);
        $display("error: %s", msg);
        n_errors++;
        test_errors++;
    endtask

    task automatic finish_test(string name);
        n_tests++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            n_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // returns on the falling edge where inst_valid is seen high
    task automatic wait_valid(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!inst_valid && cycles < WAIT_LIMIT);
        if (!inst_valid) begin
            $display("timeout, inst_valid still low after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    endtask

    // with inst_ready high the word transfers on the next rising edge
    task automatic take_expect(word_t exp_pc, bit timed);
        int cycles;
        wait_valid(cycles);
        if (timed && cycles != 3) begin
            flag_problem($sformatf("inst_valid came back %0d cycles after the transfer, not 3",
                                   cycles));
        end
        if (inst_pc !== exp_pc) error_word("inst_pc", inst_pc, exp_pc);
        if (inst !== model_word(exp_pc)) error_word("inst", inst, model_word(exp_pc));
        last_pc = exp_pc;
    endtask

    task automatic test_reset();
        // issuer sits in st_issue under rst, so loads go straight in
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_waddr <= IDX_W'(i);
            imem_wdata <= prog[IDX_W'(i)];
        end
        @(posedge clk);
        imem_we <= 1'b0; // last load lands on this edge
        repeat (8) begin
            @(negedge clk);
            if (inst_valid !== 1'b0) error_word("inst_valid", 32'(inst_valid), 32'h0);
        end
        @(posedge clk);
        rst        <= 1'b0;
        inst_ready <= 1'b1;
        take_expect(RESET_PC, 1'b0); // first word comes from the reset pc
        finish_test("reset");
    endtask

    task automatic test_sequential();
        for (int k = 0; k < 20; k++) begin
            take_expect(last_pc + 32'd4, 1'b1); // walks through every bank
        end
        finish_test("sequential");
    endtask

    task automatic test_backpressure();
        int    hold;
        word_t held_pc;
        word_t held_inst;
        repeat (4) begin
            hold = $urandom_range(1, 10);
            @(posedge clk);
            inst_ready <= 1'b0; // word already held still goes on this edge
            take_expect(last_pc + 32'd4, 1'b1);
            held_pc   = inst_pc;
            held_inst = inst;
            repeat (hold) begin
                @(negedge clk);
                if (inst_valid !== 1'b1) flag_problem("inst_valid dropped during the stall");
                if (inst_pc !== held_pc) error_word("inst_pc", inst_pc, held_pc);
                if (inst !== held_inst) error_word("inst", inst, held_inst);
            end
            @(posedge clk);
            inst_ready <= 1'b1;
            @(negedge clk); // transfer cycle
            if (inst_valid !== 1'b1) flag_problem("inst_valid gone before the transfer");
            take_expect(held_pc + 32'd4, 1'b1);
        end
        finish_test("backpressure");
    endtask

    // jump_en rides along with the next transfer
    task automatic redirect_to(word_t target);
        @(posedge clk);
        jump_en <= 1'b1;
        jump_pc <= target;
        take_expect(last_pc + 32'd4, 1'b1);
        @(posedge clk);
        jump_en <= 1'b0; // transfer on this edge still sees the jump
        jump_pc <= '0;
        take_expect(target, 1'b1);
    endtask

    task automatic test_redirect();
        word_t target;
        repeat (6) begin
            target = RESET_PC + ($urandom_range(0, MEM_WORDS - 1) << 2);
            redirect_to(target);
        end
        finish_test("redirect");
    endtask

    task automatic test_wrap();
        redirect_to(RESET_PC + word_t'((MEM_WORDS - 1) * 4)); // last word
        take_expect(last_pc + 32'd4, 1'b1); // index back at 0, pc keeps counting
        if (inst !== prog[0]) error_word("inst", inst, prog[0]);
        repeat (4) take_expect(last_pc + 32'd4, 1'b1);
        finish_test("wrap");
    endtask

    initial begin
        void'($urandom(32'h81a72129));
        clk         = 1'b0;
        rst         = 1'b1;
        jump_en     = 1'b0;
        jump_pc     = '0;
        imem_we     = 1'b0;
        imem_waddr  = '0;
        imem_wdata  = '0;
        inst_ready  = 1'b0;
        n_tests     = 0;
        n_failed    = 0;
        n_errors    = 0;
        test_errors = 0;
        last_pc     = RESET_PC;
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[IDX_W'(i)] = $urandom();
        end

        test_reset();
        test_sequential();
        test_backpressure();
        test_redirect();
        test_wrap();

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tests/fetch_sva.sv
`timescale 1ns/1ps

// decode side checks on the collector
module fetch_sva (
    input logic             clk,
    input logic             rst,
    input logic             inst_valid,
    input logic             inst_ready,
    input logic             accept,
    input fetch_pkg::word_t inst_pc,
    input fetch_pkg::word_t inst
);

    // first word needs two cycles after reset release
    a_reset_low: assert property (@(posedge clk) $fell(rst) |=> !inst_valid)
        else $error("inst_valid high one cycle after reset release");

    // payload frozen while decode stalls
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_pc))
        else $error("held instruction moved under back-pressure");

    // one accept per held word
    a_accept_pulse: assert property (@(posedge clk) disable iff (rst) accept |=> !accept)
        else $error("accept held longer than one cycle");

endmodule

bind fetch_collect fetch_sva sva_i (
    .clk       (clk),
    .rst       (rst),
    .inst_valid(inst_valid),
    .inst_ready(inst_ready),
    .accept    (accept),
    .inst_pc   (inst_pc),
    .inst      (inst)
);

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 16
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    jump_en,
    input  fetch_pkg::word_t                        jump_pc,
    input  logic                                    imem_we,
    input  logic [$clog2(NUM_BANKS*BANK_DEPTH)-1:0] imem_waddr,
    input  fetch_pkg::word_t                        imem_wdata,
    input  logic                                    inst_ready,
    output logic                                    inst_valid,
    output fetch_pkg::word_t                        inst_pc,
    output fetch_pkg::word_t                        inst
);
    import fetch_pkg::*;

    word_t issue_pc; // pc of the word in flight
    logic  accept;   // decode took the held word

    // one port per bank
    imem_port_if #(.BANK_DEPTH(BANK_DEPTH)) bank_if [NUM_BANKS-1:0] ();

    fetch_issue #(
        .NUM_BANKS (NUM_BANKS),
        .BANK_DEPTH(BANK_DEPTH)
    ) u_issue (
        .clk       (clk),
        .rst       (rst),
        .jump_en   (jump_en),
        .jump_pc   (jump_pc),
        .accept    (accept),
        .imem_we   (imem_we),
        .imem_waddr(imem_waddr),
        .imem_wdata(imem_wdata),
        .issue_pc  (issue_pc),
        .banks     (bank_if)
    );

    // interleaved banks, word index mod NUM_BANKS picks one
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        imem_bank #(
            .BANK_DEPTH(BANK_DEPTH)
        ) u_bank (
            .clk (clk),
            .port(bank_if[i])
        );
    end

    fetch_collect #(
        .NUM_BANKS(NUM_BANKS)
    ) u_collect (
        .clk       (clk),
        .rst       (rst),
        .banks     (bank_if),
        .issue_pc  (issue_pc),
        .inst_ready(inst_ready),
        .inst_valid(inst_valid),
        .inst_pc   (inst_pc),
        .inst      (inst),
        .accept    (accept)
    );

endmodule

// File: hw/fetch_collect.sv
`timescale 1ns/1ps

module fetch_collect #(
    parameter int NUM_BANKS = 4
) (
    input  logic             clk,
    input  logic             rst,
    imem_port_if.collector   banks [NUM_BANKS-1:0],
    input  fetch_pkg::word_t issue_pc,
    input  logic             inst_ready,
    output logic             inst_valid,
    output fetch_pkg::word_t inst_pc,
    output fetch_pkg::word_t inst,
    output logic             accept
);
    import fetch_pkg::*;

    logic [NUM_BANKS-1:0] rv;                    // per-bank rvalid
    word_t                rd_masked [NUM_BANKS]; // rdata, zero unless valid
    logic                 rsp_valid;
    word_t                rsp_data;

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_rsp
        assign rv[i]        = banks[i].rvalid;
        assign rd_masked[i] = banks[i].rvalid ? banks[i].rdata : '0;
    end

    // at most one bank answers, so an OR is enough
    always_comb begin
        rsp_data = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            rsp_data = rsp_data | rd_masked[i];
        end
    end

    assign rsp_valid = |rv;
    assign accept    = inst_valid && inst_ready; // transfer cycle pulse

    // valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid <= 1'b0;
        end else if (rsp_valid) begin
            inst_valid <= 1'b1;
        end else if (accept) begin
            inst_valid <= 1'b0; // next word is at least 3 cycles away
        end
    end

    // payload, held stable until the transfer
    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            inst    <= rsp_data;
            inst_pc <= issue_pc; // pc only moves on accept
        end
    end

endmodule

// File: hw/imem_bank.sv
`timescale 1ns/1ps

// one interleaved slice of instruction memory
module imem_bank #(
    parameter int BANK_DEPTH = 16
) (
    input  logic     clk,
    imem_port_if.bank port
);
    import fetch_pkg::*;

    word_t mem [BANK_DEPTH]; // no init, program comes in over the load port

    // loads
    always_ff @(posedge clk) begin
        if (port.req && port.we) begin
            mem[port.row] <= port.wdata;
        end
    end

    // registered read, answer one cycle after req
    always_ff @(posedge clk) begin
        port.rvalid <= port.req && !port.we; // single cycle pulse
        if (port.req && !port.we) begin
            port.rdata <= mem[port.row];
        end
    end

endmodule

// File: hw/fetch_issue.sv
`timescale 1ns/1ps

module fetch_issue #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   jump_en,
    input  fetch_pkg::word_t                       jump_pc,
    input  logic                                   accept,
    input  logic                                   imem_we,
    input  logic [$clog2(NUM_BANKS*BANK_DEPTH)-1:0] imem_waddr,
    input  fetch_pkg::word_t                       imem_wdata,
    output fetch_pkg::word_t                       issue_pc,
    imem_port_if.issuer                            banks [NUM_BANKS-1:0]
);
    import fetch_pkg::*;

    localparam int IDX_W  = $clog2(NUM_BANKS * BANK_DEPTH); // word index over all banks
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int ROW_W  = $clog2(BANK_DEPTH);

    fetch_state_t      state;
    word_t             pc;
    word_t             pc_off;    // byte offset from the memory base
    logic [IDX_W-1:0]  rd_idx;    // word index of pc, wraps with total size
    logic              rd_go;     // fetch read this cycle
    logic              ld_go;     // program load this cycle
    logic [BANK_W-1:0] sel_bank;
    logic [ROW_W-1:0]  sel_row;

    // index rule: low bits pick the bank, the rest the row
    always_comb begin
        pc_off = pc - RESET_PC;
        rd_idx = pc_off[IDX_W+1:2]; // drop byte bits, upper bits wrap away

        // no reads while rst is high, that is the load window
        rd_go = (state == st_issue) && !rst;
        ld_go = imem_we && (state == st_issue) && !rd_go;

        // loads use the same interleave as fetches
        if (rd_go) begin
            sel_bank = rd_idx[BANK_W-1:0];
            sel_row  = rd_idx[IDX_W-1:BANK_W];
        end else begin
            sel_bank = imem_waddr[BANK_W-1:0];
            sel_row  = imem_waddr[IDX_W-1:BANK_W];
        end
    end

    // only the selected bank sees req
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_port
        assign banks[i].req   = (rd_go || ld_go) && (sel_bank == BANK_W'(i));
        assign banks[i].we    = ld_go;
        assign banks[i].row   = sel_row;   // broadcast, req qualifies it
        assign banks[i].wdata = imem_wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_issue;
            pc    <= RESET_PC;
        end else begin
            case (state)
                st_issue: begin
                    state <= st_wait_mem; // read went out this cycle
                end
                st_wait_mem: begin
                    state <= st_wait_ready; // collector registers the word now
                end
                st_wait_ready: begin
                    // redirect sampled only on the transfer cycle
                    if (accept) begin
                        state <= st_issue;
                        pc    <= jump_en ? jump_pc : pc + 32'd4;
                    end
                end
                default: state <= st_issue;
            endcase
        end
    end

    // pc stays put until accept, so it tags the word in flight
    assign issue_pc = pc;

endmodule

// File: hw/imem_port_if.sv
`timescale 1ns/1ps

// one bank's request and response signals
interface imem_port_if #(
    parameter int BANK_DEPTH = 16
);
    import fetch_pkg::*;

    localparam int ROW_W = $clog2(BANK_DEPTH);

    logic             req;    // access strobe
    logic             we;     // 1 = load, 0 = fetch read
    logic [ROW_W-1:0] row;    // word within this bank
    word_t            wdata;  // load data
    logic             rvalid; // one cycle after a read
    word_t            rdata;

    modport issuer (
        output req, we, row, wdata
    );

    modport bank (
        input  req, we, row, wdata,
        output rvalid, rdata
    );

    modport collector (
        input rvalid, rdata
    );

endinterface

// File: hw/fetch_pkg.sv
package fetch_pkg;

    // one instruction or one byte address
    typedef logic [31:0] word_t;

    // first instruction after reset, also the base of the memory window
    localparam word_t RESET_PC = 32'h8000_0000;

    // issuer states
    // a word is fetched strictly one at a time, so there is never
    // more than one read in flight
    typedef enum logic [1:0] {
        st_issue,      // read goes out this cycle
        st_wait_mem,   // bank answers next edge
        st_wait_ready  // word held in collector until decode takes it
    } fetch_state_t;

endpackage
